//--- logic/rob_macros.svh
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// buffer geometry
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// allocations and retirements per cycle
`define RETIRE_W 2

// writeback ports of the ALU kind
`define ALU_PORTS 2

// register file
`define REG_W 32
`define AREG_W 5

`endif

//--- logic/commit_pkg.sv
package commit_pkg;

    // exception code carried by a writeback, NONE means clean
    typedef enum logic [2:0] {
        NONE       = 3'd0,
        ILLEGAL    = 3'd1,
        MISALIGN   = 3'd2,
        LOAD_FAULT = 3'd3,
        OVERFLOW   = 3'd4
    } exc_code_t;

    // writeback ports in merge order, later ones win a clash
    typedef enum logic [1:0] {
        WB_ALU0   = 2'd0,
        WB_ALU1   = 2'd1,
        WB_LOAD   = 2'd2,
        WB_BRANCH = 2'd3
    } wb_port_t;

    localparam int WB_PORTS = 4;

endpackage

//--- logic/rob_pkg.sv
`include "rob_macros.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        ALU    = 2'd0,
        LOAD   = 2'd1,
        BRANCH = 2'd2
    } entry_kind_t;

    // branch outcome, target kept as a word address
    typedef struct packed {
        logic        taken;
        logic [30:0] target;
    } br_result_t;

    // same word, read by entry kind
    typedef union packed {
        logic [`REG_W-1:0] value;
        br_result_t        br;
    } result_u;

    typedef struct packed {
        logic                  valid;
        logic                  complete;
        entry_kind_t           kind;
        logic [`AREG_W-1:0]    dest;
        logic                  has_dest;
        commit_pkg::exc_code_t exc;
        result_u               result;
    } rob_entry_t;

endpackage

//--- logic/rob_ptr_ctrl.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_ptr_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic [`RETIRE_W-1:0]  alloc_valid,
    input  logic [1:0]            retire_cnt,
    output logic [`ROB_IDX_W-1:0] head_idx,
    output logic [`ROB_IDX_W-1:0] tail_idx,
    output logic [`ROB_IDX_W-1:0] alloc_idx [`RETIRE_W],
    output logic                  space_ok
);

    // index plus wrap bit
    logic [`ROB_IDX_W:0] head_ptr;
    logic [`ROB_IDX_W:0] tail_ptr;

    logic [`ROB_IDX_W:0] alloc_cnt;
    logic [`ROB_IDX_W:0] used_cnt;
    logic [`ROB_IDX_W:0] free_cnt;

    assign head_idx = head_ptr[`ROB_IDX_W-1:0];
    assign tail_idx = tail_ptr[`ROB_IDX_W-1:0];

    // lane 1 only ever rides along with lane 0
    assign alloc_cnt = (`ROB_IDX_W+1)'(alloc_valid[0]) + (`ROB_IDX_W+1)'(alloc_valid[1]);

    // wrap bit makes full and empty distinct
    assign used_cnt = tail_ptr - head_ptr;
    assign free_cnt = (`ROB_IDX_W+1)'(`ROB_DEPTH) - used_cnt;
    assign space_ok = free_cnt >= (`ROB_IDX_W+1)'(`RETIRE_W);

    always_comb begin
        for (int l = 0; l < `RETIRE_W; l++) begin
            alloc_idx[l] = tail_idx + `ROB_IDX_W'(l);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + (`ROB_IDX_W+1)'(retire_cnt);
            tail_ptr <= tail_ptr + alloc_cnt;
        end
    end

endmodule

//--- logic/rob_table.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_table (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,

    input  logic [`RETIRE_W-1:0]  alloc_valid,
    input  logic [`ROB_IDX_W-1:0] alloc_idx [`RETIRE_W],
    input  rob_pkg::entry_kind_t  alloc_kind [`RETIRE_W],
    input  logic [`AREG_W-1:0]    alloc_dest [`RETIRE_W],
    input  logic                  alloc_has_dest [`RETIRE_W],

    input  logic [`RETIRE_W-1:0]  retire_clear,
    input  logic [`ROB_IDX_W-1:0] head_idx,

    input  logic                  alu_wb_valid [`ALU_PORTS],
    input  logic [`ROB_IDX_W-1:0] alu_wb_idx [`ALU_PORTS],
    input  logic [`REG_W-1:0]     alu_wb_data [`ALU_PORTS],
    input  commit_pkg::exc_code_t alu_wb_exc [`ALU_PORTS],

    input  logic                  ld_wb_valid,
    input  logic [`ROB_IDX_W-1:0] ld_wb_idx,
    input  logic [`REG_W-1:0]     ld_wb_data,
    input  commit_pkg::exc_code_t ld_wb_exc,

    input  logic                  br_wb_valid,
    input  logic [`ROB_IDX_W-1:0] br_wb_idx,
    input  logic                  br_wb_taken,
    input  logic [30:0]           br_wb_target,
    input  commit_pkg::exc_code_t br_wb_exc,

    output rob_pkg::rob_entry_t   entries [`ROB_DEPTH]
);

    rob_pkg::rob_entry_t table_q [`ROB_DEPTH];
    rob_pkg::rob_entry_t table_d [`ROB_DEPTH];

    // writeback ports gathered into one indexed view
    logic                  wb_valid  [commit_pkg::WB_PORTS];
    logic [`ROB_IDX_W-1:0] wb_idx    [commit_pkg::WB_PORTS];
    commit_pkg::exc_code_t wb_exc    [commit_pkg::WB_PORTS];
    rob_pkg::result_u      wb_result [commit_pkg::WB_PORTS];

    always_comb begin
        for (int a = 0; a < `ALU_PORTS; a++) begin
            wb_valid[int'(commit_pkg::WB_ALU0) + a]        = alu_wb_valid[a];
            wb_idx[int'(commit_pkg::WB_ALU0) + a]          = alu_wb_idx[a];
            wb_exc[int'(commit_pkg::WB_ALU0) + a]          = alu_wb_exc[a];
            wb_result[int'(commit_pkg::WB_ALU0) + a].value = alu_wb_data[a];
        end

        wb_valid[int'(commit_pkg::WB_LOAD)]        = ld_wb_valid;
        wb_idx[int'(commit_pkg::WB_LOAD)]          = ld_wb_idx;
        wb_exc[int'(commit_pkg::WB_LOAD)]          = ld_wb_exc;
        wb_result[int'(commit_pkg::WB_LOAD)].value = ld_wb_data;

        // branch port fills the other view of the union
        wb_valid[int'(commit_pkg::WB_BRANCH)]            = br_wb_valid;
        wb_idx[int'(commit_pkg::WB_BRANCH)]              = br_wb_idx;
        wb_exc[int'(commit_pkg::WB_BRANCH)]              = br_wb_exc;
        wb_result[int'(commit_pkg::WB_BRANCH)].br.taken  = br_wb_taken;
        wb_result[int'(commit_pkg::WB_BRANCH)].br.target = br_wb_target;
    end

    always_comb begin
        logic [`ROB_IDX_W-1:0] slot;

        table_d = table_q;

        // drop what retired this cycle
        for (int l = 0; l < `RETIRE_W; l++) begin
            slot = head_idx + `ROB_IDX_W'(l);
            if (retire_clear[l]) begin
                table_d[slot] = '0;
            end
        end

        // port order gives branch over load over alu
        for (int p = 0; p < commit_pkg::WB_PORTS; p++) begin
            if (wb_valid[p]) begin
                table_d[wb_idx[p]].complete = 1'b1;
                table_d[wb_idx[p]].exc      = wb_exc[p];
                table_d[wb_idx[p]].result   = wb_result[p];
            end
        end

        // new entries last
        for (int l = 0; l < `RETIRE_W; l++) begin
            if (alloc_valid[l]) begin
                table_d[alloc_idx[l]].valid    = 1'b1;
                table_d[alloc_idx[l]].complete = 1'b0;
                table_d[alloc_idx[l]].kind     = alloc_kind[l];
                table_d[alloc_idx[l]].dest     = alloc_dest[l];
                table_d[alloc_idx[l]].has_dest = alloc_has_dest[l];
                table_d[alloc_idx[l]].exc      = commit_pkg::NONE;
                table_d[alloc_idx[l]].result   = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            table_q <= '{default: '0};
        end else begin
            table_q <= table_d;
        end
    end

    assign entries = table_q;

endmodule

//--- logic/rob_retire_sel.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_retire_sel (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  rob_pkg::rob_entry_t   entries [`ROB_DEPTH],
    input  logic [`ROB_IDX_W-1:0] head_idx,

    output logic [1:0]            retire_cnt,
    output logic [`RETIRE_W-1:0]  retire_clear,

    output logic                  rf_we [`RETIRE_W],
    output logic [`AREG_W-1:0]    rf_addr [`RETIRE_W],
    output logic [`REG_W-1:0]     rf_data [`RETIRE_W],
    output logic                  redirect_valid,
    output logic [`REG_W-1:0]     redirect_target,
    output logic                  exc_valid,
    output logic [`ROB_IDX_W-1:0] exc_idx,
    output commit_pkg::exc_code_t exc_code
);

    // held after a redirect or exception until flush
    logic blocked;

    logic                  we_d [`RETIRE_W];
    logic [`AREG_W-1:0]    addr_d [`RETIRE_W];
    logic [`REG_W-1:0]     data_d [`RETIRE_W];
    logic                  redir_d;
    logic [`REG_W-1:0]     target_d;
    logic                  exc_d;
    logic [`ROB_IDX_W-1:0] exc_idx_d;
    commit_pkg::exc_code_t exc_code_d;

    always_comb begin
        logic                  stop;
        logic [`ROB_IDX_W-1:0] slot;
        rob_pkg::rob_entry_t   e;

        stop         = blocked;
        retire_cnt   = 2'd0;
        retire_clear = '0;
        redir_d      = 1'b0;
        target_d     = '0;
        exc_d        = 1'b0;
        exc_idx_d    = '0;
        exc_code_d   = commit_pkg::NONE;

        for (int l = 0; l < `RETIRE_W; l++) begin
            slot      = head_idx + `ROB_IDX_W'(l);
            e         = entries[slot];
            we_d[l]   = 1'b0;
            addr_d[l] = e.dest;
            data_d[l] = e.result.value;

            if (!stop) begin
                if (!(e.valid && e.complete)) begin
                    stop = 1'b1;
                end else if (e.exc != commit_pkg::NONE) begin
                    // reported, never retired
                    exc_d      = 1'b1;
                    exc_idx_d  = slot;
                    exc_code_d = e.exc;
                    stop       = 1'b1;
                end else begin
                    retire_cnt      = retire_cnt + 2'd1;
                    retire_clear[l] = 1'b1;
                    // branches write no register
                    we_d[l] = e.has_dest && (e.kind != rob_pkg::BRANCH);
                    if (e.kind == rob_pkg::BRANCH && e.result.br.taken) begin
                        redir_d  = 1'b1;
                        target_d = {e.result.br.target[`REG_W-3:0], 2'b00};
                        stop     = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            blocked        <= 1'b0;
            redirect_valid <= 1'b0;
            exc_valid      <= 1'b0;
            for (int l = 0; l < `RETIRE_W; l++) begin
                rf_we[l] <= 1'b0;
            end
        end else begin
            blocked        <= blocked || redir_d || exc_d;
            redirect_valid <= redir_d;
            exc_valid      <= exc_d;
            for (int l = 0; l < `RETIRE_W; l++) begin
                rf_we[l] <= we_d[l];
            end
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        redirect_target <= target_d;
        exc_idx         <= exc_idx_d;
        exc_code        <= exc_code_d;
        for (int l = 0; l < `RETIRE_W; l++) begin
            rf_addr[l] <= addr_d[l];
            rf_data[l] <= data_d[l];
        end
    end

endmodule

//--- logic/rob_top.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,

    // rename side
    input  logic [`RETIRE_W-1:0]  alloc_valid,
    input  rob_pkg::entry_kind_t  alloc_kind [`RETIRE_W],
    input  logic [`AREG_W-1:0]    alloc_dest [`RETIRE_W],
    input  logic                  alloc_has_dest [`RETIRE_W],
    output logic [`ROB_IDX_W-1:0] alloc_idx [`RETIRE_W],
    output logic                  space_ok,

    // writeback
    input  logic                  alu_wb_valid [`ALU_PORTS],
    input  logic [`ROB_IDX_W-1:0] alu_wb_idx [`ALU_PORTS],
    input  logic [`REG_W-1:0]     alu_wb_data [`ALU_PORTS],
    input  commit_pkg::exc_code_t alu_wb_exc [`ALU_PORTS],
    input  logic                  ld_wb_valid,
    input  logic [`ROB_IDX_W-1:0] ld_wb_idx,
    input  logic [`REG_W-1:0]     ld_wb_data,
    input  commit_pkg::exc_code_t ld_wb_exc,
    input  logic                  br_wb_valid,
    input  logic [`ROB_IDX_W-1:0] br_wb_idx,
    input  logic                  br_wb_taken,
    input  logic [30:0]           br_wb_target,
    input  commit_pkg::exc_code_t br_wb_exc,

    // retire
    output logic                  rf_we [`RETIRE_W],
    output logic [`AREG_W-1:0]    rf_addr [`RETIRE_W],
    output logic [`REG_W-1:0]     rf_data [`RETIRE_W],
    output logic                  redirect_valid,
    output logic [`REG_W-1:0]     redirect_target,
    output logic                  exc_valid,
    output logic [`ROB_IDX_W-1:0] exc_idx,
    output commit_pkg::exc_code_t exc_code
);

    logic [`ROB_IDX_W-1:0] head_idx;
    // observed by the bound checker
    logic [`ROB_IDX_W-1:0] tail_idx;
    logic [1:0]            retire_cnt;
    logic [`RETIRE_W-1:0]  retire_clear;
    rob_pkg::rob_entry_t   entries [`ROB_DEPTH];

    rob_ptr_ctrl ptr0 (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .alloc_valid(alloc_valid),
        .retire_cnt (retire_cnt),
        .head_idx   (head_idx),
        .tail_idx   (tail_idx),
        .alloc_idx  (alloc_idx),
        .space_ok   (space_ok)
    );

    rob_table table0 (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .alloc_valid   (alloc_valid),
        .alloc_idx     (alloc_idx),
        .alloc_kind    (alloc_kind),
        .alloc_dest    (alloc_dest),
        .alloc_has_dest(alloc_has_dest),
        .retire_clear  (retire_clear),
        .head_idx      (head_idx),
        .alu_wb_valid  (alu_wb_valid),
        .alu_wb_idx    (alu_wb_idx),
        .alu_wb_data   (alu_wb_data),
        .alu_wb_exc    (alu_wb_exc),
        .ld_wb_valid   (ld_wb_valid),
        .ld_wb_idx     (ld_wb_idx),
        .ld_wb_data    (ld_wb_data),
        .ld_wb_exc     (ld_wb_exc),
        .br_wb_valid   (br_wb_valid),
        .br_wb_idx     (br_wb_idx),
        .br_wb_taken   (br_wb_taken),
        .br_wb_target  (br_wb_target),
        .br_wb_exc     (br_wb_exc),
        .entries       (entries)
    );

    rob_retire_sel retire0 (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .entries        (entries),
        .head_idx       (head_idx),
        .retire_cnt     (retire_cnt),
        .retire_clear   (retire_clear),
        .rf_we          (rf_we),
        .rf_addr        (rf_addr),
        .rf_data        (rf_data),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target),
        .exc_valid      (exc_valid),
        .exc_idx        (exc_idx),
        .exc_code       (exc_code)
    );

endmodule

//--- tests/rob_assert.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  flush,
    input logic [`RETIRE_W-1:0]  alloc_valid,
    input logic                  space_ok,
    input logic                  alu_wb_valid [`ALU_PORTS],
    input logic [`ROB_IDX_W-1:0] alu_wb_idx [`ALU_PORTS],
    input logic                  ld_wb_valid,
    input logic [`ROB_IDX_W-1:0] ld_wb_idx,
    input logic                  br_wb_valid,
    input logic [`ROB_IDX_W-1:0] br_wb_idx,
    input logic                  rf_we [`RETIRE_W],
    input logic                  redirect_valid,
    input logic                  exc_valid,
    input logic [`ROB_IDX_W-1:0] tail_idx
);

    logic wb_clash;

    // any two writeback ports naming one entry
    always_comb begin
        logic [3:0]            v;
        logic [`ROB_IDX_W-1:0] ix [4];
        v = {br_wb_valid, ld_wb_valid, alu_wb_valid[1], alu_wb_valid[0]};
        ix[0] = alu_wb_idx[0];
        ix[1] = alu_wb_idx[1];
        ix[2] = ld_wb_idx;
        ix[3] = br_wb_idx;
        wb_clash = 1'b0;
        for (int i = 0; i < 4; i++) begin
            for (int j = i + 1; j < 4; j++) begin
                if (v[i] && v[j] && ix[i] == ix[j]) begin
                    wb_clash = 1'b1;
                end
            end
        end
    end

    a_space: assert property (@(posedge clk) disable iff (reset)
        (alloc_valid != '0) |-> space_ok)
        else $error("allocation while space_ok is low");

    a_lane: assert property (@(posedge clk) disable iff (reset)
        alloc_valid[1] |-> alloc_valid[0])
        else $error("lane 1 allocated without lane 0");

    a_clash: assert property (@(posedge clk) disable iff (reset) !wb_clash)
        else $error("two writebacks to one entry in the same cycle");

    a_excl: assert property (@(posedge clk) disable iff (reset)
        !(exc_valid && redirect_valid))
        else $error("exception and redirect strobes together");

    a_hold: assert property (@(posedge clk) disable iff (reset)
        exc_valid |=> !(exc_valid || redirect_valid || rf_we[0] || rf_we[1]))
        else $error("retire strobe right after an exception");

    a_flush: assert property (@(posedge clk) disable iff (reset)
        flush |=> tail_idx == '0)
        else $error("tail not cleared by flush");

endmodule

bind rob_top rob_assert assert0 (.*);

//--- tests/rob_tb.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_tb;

    // etype 0 register write, 1 redirect, 2 exception
    typedef struct {
        int          etype;
        logic [31:0] a;
        logic [31:0] d;
    } retire_ev_t;

    localparam int TOTAL_LEN = 6 + 8 + 6 + 6 + 6;
    localparam int TIMEOUT_CYCLES = TOTAL_LEN * 20;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  flush;
    logic [`RETIRE_W-1:0]  alloc_valid;
    rob_pkg::entry_kind_t  alloc_kind [`RETIRE_W];
    logic [`AREG_W-1:0]    alloc_dest [`RETIRE_W];
    logic                  alloc_has_dest [`RETIRE_W];
    logic [`ROB_IDX_W-1:0] alloc_idx [`RETIRE_W];
    logic                  space_ok;
    logic                  alu_wb_valid [`ALU_PORTS];
    logic [`ROB_IDX_W-1:0] alu_wb_idx [`ALU_PORTS];
    logic [`REG_W-1:0]     alu_wb_data [`ALU_PORTS];
    commit_pkg::exc_code_t alu_wb_exc [`ALU_PORTS];
    logic                  ld_wb_valid;
    logic [`ROB_IDX_W-1:0] ld_wb_idx;
    logic [`REG_W-1:0]     ld_wb_data;
    commit_pkg::exc_code_t ld_wb_exc;
    logic                  br_wb_valid;
    logic [`ROB_IDX_W-1:0] br_wb_idx;
    logic                  br_wb_taken;
    logic [30:0]           br_wb_target;
    commit_pkg::exc_code_t br_wb_exc;
    logic                  rf_we [`RETIRE_W];
    logic [`AREG_W-1:0]    rf_addr [`RETIRE_W];
    logic [`REG_W-1:0]     rf_data [`RETIRE_W];
    logic                  redirect_valid;
    logic [`REG_W-1:0]     redirect_target;
    logic                  exc_valid;
    logic [`ROB_IDX_W-1:0] exc_idx;
    commit_pkg::exc_code_t exc_code;

    int                    errors = 0;
    int                    mismatches = 0;
    // taps of x^17 + x^14 + 1
    logic [16:0]           lfsr = 17'd65991;
    logic [`ROB_IDX_W-1:0] exp_tail = '0;
    retire_ev_t            exp_q [$];
    rob_pkg::rob_entry_t   batch [$];

    rob_top dut0 (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // expected retire stream of the batch, in program order
    function automatic void expect_retires(logic [`ROB_IDX_W-1:0] start);
        rob_pkg::rob_entry_t e;
        foreach (batch[k]) begin
            e = batch[k];
            if (e.exc != commit_pkg::NONE) begin
                exp_q.push_back('{2, 32'((int'(start) + k) % `ROB_DEPTH), 32'(e.exc)});
                return;
            end
            if (e.kind == rob_pkg::BRANCH) begin
                if (e.result.br.taken) begin
                    exp_q.push_back('{1, 32'd0, 32'(e.result.br.target) * 32'd4});
                    return;
                end
            end else if (e.has_dest) begin
                exp_q.push_back('{0, 32'(e.dest), e.result.value});
            end
        end
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic next_expect(input int etype, input string what,
                               output retire_ev_t ev, output bit ok);
        ok = exp_q.size() > 0 && exp_q[0].etype == etype;
        assert (ok) else begin
            errors++;
            $display("unexpected %s at %0t", what, $time);
        end
        if (ok) begin
            ev = exp_q.pop_front();
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        retire_ev_t ev;
        bit         ok;
        if (!reset) begin
            for (int l = 0; l < `RETIRE_W; l++) begin
                if (rf_we[l]) begin
                    next_expect(0, "register write", ev, ok);
                    if (ok) begin
                        check("rf_addr", 32'(rf_addr[l]), ev.a);
                        check("rf_data", rf_data[l], ev.d);
                    end
                end
            end
            if (redirect_valid) begin
                next_expect(1, "redirect", ev, ok);
                if (ok) begin
                    check("redirect_target", redirect_target, ev.d);
                end
            end
            if (exc_valid) begin
                next_expect(2, "exception", ev, ok);
                if (ok) begin
                    check("exc_idx", 32'(exc_idx), ev.a);
                    check("exc_code", 32'(exc_code), ev.d);
                end
            end
        end
    end

    task automatic idle_inputs();
        alloc_valid = '0;
        ld_wb_valid = 1'b0;
        br_wb_valid = 1'b0;
        for (int l = 0; l < `RETIRE_W; l++) begin
            alloc_kind[l] = rob_pkg::ALU;
            alloc_dest[l] = '0;
            alloc_has_dest[l] = 1'b0;
            alu_wb_valid[l] = 1'b0;
            alu_wb_idx[l] = '0;
            alu_wb_data[l] = '0;
            alu_wb_exc[l] = commit_pkg::NONE;
        end
        ld_wb_idx = '0;
        ld_wb_data = '0;
        ld_wb_exc = commit_pkg::NONE;
        br_wb_idx = '0;
        br_wb_taken = 1'b0;
        br_wb_target = '0;
        br_wb_exc = commit_pkg::NONE;
    endtask

    task automatic write_back(input rob_pkg::rob_entry_t e, input logic [`ROB_IDX_W-1:0] idx);
        int p;
        if (e.kind == rob_pkg::BRANCH) begin
            br_wb_valid = 1'b1;
            br_wb_idx = idx;
            br_wb_taken = e.result.br.taken;
            br_wb_target = e.result.br.target;
            br_wb_exc = e.exc;
        end else if (e.kind == rob_pkg::LOAD) begin
            ld_wb_valid = 1'b1;
            ld_wb_idx = idx;
            ld_wb_data = e.result.value;
            ld_wb_exc = e.exc;
        end else begin
            p = int'(rand_bits(1));
            alu_wb_valid[p] = 1'b1;
            alu_wb_idx[p] = idx;
            alu_wb_data[p] = e.result.value;
            alu_wb_exc[p] = e.exc;
        end
    endtask

    // mode 0 mixed, 1 alu only, 2 taken branch, 3 not-taken branch, 4 exception
    task automatic run_batch(input int n, input int mode, input bit do_flush);
        int                    order [$];
        int                    pos;
        int                    done;
        int                    cnt;
        int                    j;
        int                    tmp;
        logic [`ROB_IDX_W-1:0] start;
        rob_pkg::rob_entry_t   e;
        batch.delete();
        start = exp_tail;
        pos = int'(rand_bits(3)) % n;
        for (int k = 0; k < n; k++) begin
            e = '0;
            e.valid = 1'b1;
            e.kind = (mode == 1 || rand_bits(1) == 0) ? rob_pkg::ALU : rob_pkg::LOAD;
            e.dest = `AREG_W'(rand_bits(5));
            e.has_dest = rand_bits(2) != 0;
            e.result.value = rand_bits(32);
            if ((mode == 2 || mode == 3) && k == pos) begin
                e.kind = rob_pkg::BRANCH;
                e.has_dest = 1'b0;
                e.result.br.taken = mode == 2;
                e.result.br.target = 31'(rand_bits(31));
            end
            if (mode == 4 && k == pos) begin
                e.exc = commit_pkg::exc_code_t'(3'(1 + rand_bits(2)));
            end
            batch.push_back(e);
            order.push_back(k);
        end
        expect_retires(start);

        done = 0;
        while (done < n) begin
            @(negedge clk);
            idle_inputs();
            check("alloc_idx[0]", 32'(alloc_idx[0]), 32'(exp_tail));
            check("alloc_idx[1]", 32'(alloc_idx[1]),
                  32'((int'(exp_tail) + 1) % `ROB_DEPTH));
            assert (space_ok) else begin
                errors++;
                $display("space_ok low while the batch still had room at %0t", $time);
            end
            // a full buffer takes its last two entries as one pair
            cnt = (n - done >= 2 &&
                   (done == 6 || (done != 5 && rand_bits(1) != 0))) ? 2 : 1;
            for (int l = 0; l < cnt; l++) begin
                alloc_kind[l] = batch[done + l].kind;
                alloc_dest[l] = batch[done + l].dest;
                alloc_has_dest[l] = batch[done + l].has_dest;
            end
            alloc_valid = (cnt == 2) ? 2'b11 : 2'b01;
            done += cnt;
            exp_tail += `ROB_IDX_W'(cnt);
        end
        @(negedge clk);
        idle_inputs();
        if (mode == 1) begin
            check("space_ok", 32'(space_ok), 32'd0);
        end

        for (int k = n - 1; k > 0; k--) begin
            j = int'(rand_bits(3)) % (k + 1);
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            write_back(batch[order[k]], start + `ROB_IDX_W'(order[k]));
            @(negedge clk);
            idle_inputs();
        end

        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
        // drain retirements that leave no strobe
        repeat (6) @(negedge clk);
        if (!do_flush) begin
            check("space_ok", 32'(space_ok), 32'd1);
        end else begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            exp_tail = '0;
            check("space_ok", 32'(space_ok), 32'd1);
        end
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        idle_inputs();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_batch(6, 0, 1'b0);
        run_batch(8, 1, 1'b0);
        run_batch(6, 2, 1'b1);
        run_batch(6, 3, 1'b0);
        run_batch(6, 4, 1'b1);
        $display("errors: %0d mismatches, %0d other failures", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/commit_pkg.sv
logic/rob_pkg.sv
logic/rob_ptr_ctrl.sv
logic/rob_table.sv
logic/rob_retire_sel.sv
logic/rob_top.sv
tests/rob_assert.sv
tests/rob_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= rob_tb
FILELIST  ?= project.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
